/* hw/link_defs.svh */
//////////////////////////////////////////////////////////////////////
// Link configuration
// Credit count, user data width and buffer depths
//////////////////////////////////////////////////////////////////////

`ifndef LINK_DEFS_SVH
`define LINK_DEFS_SVH

// Credits each side starts with, also the channel FIFO depth
`define LINK_NUM_CREDITS 8

// Width of one user data word
`define LINK_DATA_W 16

// Endpoint output register FIFO
`define LINK_OUT_DEPTH 2

`endif

/* hw/link_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Link package
// Packet tag, credit, data and payload types shared by the link
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "link_defs.svh"

package link_pkg;

  // Packet kind carried in the payload header
  typedef enum logic [1:0] {
    TagIdle = 2'b00,
    TagReq  = 2'b01,
    TagRsp  = 2'b10
  } link_tag_e;

  // Wide enough for 0 to LINK_NUM_CREDITS
  typedef logic [3:0] link_credit_t;

  typedef logic [`LINK_DATA_W-1:0] link_data_t;

  typedef struct packed {
    link_tag_e    tag;
    link_credit_t credit;
    link_data_t   data;
  } link_payload_t;

endpackage

`default_nettype wire

/* hw/link_fifo.sv */
//////////////////////////////////////////////////////////////////////
// Stream FIFO
// Circular buffer with valid/ready on both sides, entry type by parameter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module link_fifo #(
  parameter int unsigned DEPTH = 2,
  parameter type         T     = logic
) (
  input  wire logic clk_i,
  input  wire logic arst_n_i,
  input  wire logic valid_i,
  output logic      ready_o,
  input  wire T     data_i,
  output logic      valid_o,
  input  wire logic ready_i,
  output T          data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // Head is registered storage, so a push shows up one cycle later
  assign ready_o = (count_q != CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  a_fill_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    count_q <= CNT_W'(DEPTH));

  // Stalled head must hold until taken
  a_head_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

`default_nettype wire

/* hw/link_packer.sv */
//////////////////////////////////////////////////////////////////////
// Link packer
// Merges request and response streams into one payload stream and
// keeps the credit accounting for both directions
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "link_defs.svh"

module link_packer import link_pkg::*; (
  input  wire logic         clk_i,
  input  wire logic         arst_n_i,
  input  wire logic         req_valid_i,
  input  wire link_data_t   req_data_i,
  input  wire logic         rsp_valid_i,
  input  wire link_data_t   rsp_data_i,
  input  wire logic         payload_ready_i,
  input  wire logic         pkt_acc_i,
  input  wire link_credit_t credit_ret_i,
  output logic              req_ready_o,
  output logic              rsp_ready_o,
  output logic              payload_valid_o,
  output link_payload_t     payload_o
);

  // Owed credits at which a credit-only packet goes out
  localparam int FORCE_THRESH = `LINK_NUM_CREDITS - 4;

  logic         entropy_q;
  link_credit_t credits_out_q;
  link_credit_t credits_out_d;
  link_credit_t credits_to_send_q;
  link_credit_t credits_to_send_d;
  logic         req_gnt;
  logic         rsp_gnt;
  logic         force_send;
  logic         credit_ok;
  logic         payload_fire;

  //////////////////////////////////////////////////////////////////////
  // Arbitration and payload forming
  //////////////////////////////////////////////////////////////////////

  // Entropy bit breaks the tie when both streams are valid
  assign req_gnt = req_valid_i & (~rsp_valid_i | ~entropy_q);
  assign rsp_gnt = rsp_valid_i & (~req_valid_i | entropy_q);

  assign force_send = (credits_to_send_q >= link_credit_t'(FORCE_THRESH));

  // Spend the last credit only when credits go back with it, otherwise
  // both sides could end up waiting on each other
  assign credit_ok = (credits_out_q > link_credit_t'(1)) ||
                     ((credits_out_q == link_credit_t'(1)) && (credits_to_send_q != '0));

  assign payload_valid_o = (req_gnt | rsp_gnt | force_send) & credit_ok;
  assign payload_fire    = payload_valid_o & payload_ready_i;

  assign req_ready_o = req_gnt & payload_fire;
  assign rsp_ready_o = rsp_gnt & payload_fire;

  always_comb begin
    payload_o        = '0;
    payload_o.credit = credits_to_send_q;
    if (req_gnt) begin
      payload_o.tag  = TagReq;
      payload_o.data = req_data_i;
    end else if (rsp_gnt) begin
      payload_o.tag  = TagRsp;
      payload_o.data = rsp_data_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Credit counters
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    credits_out_d     = credits_out_q;
    credits_to_send_d = credits_to_send_q;
    // Send first, then add what came in on the same edge
    if (payload_fire) begin
      credits_out_d     = credits_out_q - 1'b1;
      credits_to_send_d = '0;
    end
    if (pkt_acc_i) begin
      credits_out_d     = credits_out_d + credit_ret_i;
      credits_to_send_d = credits_to_send_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credits_out_q     <= link_credit_t'(`LINK_NUM_CREDITS);
      credits_to_send_q <= '0;
      entropy_q         <= 1'b0;
    end else begin
      credits_out_q     <= credits_out_d;
      credits_to_send_q <= credits_to_send_d;
      if (payload_fire) begin
        entropy_q <= ~entropy_q;
      end
    end
  end

  initial begin
    a_force_thresh: assert (FORCE_THRESH > 0);
  end

  // Far side can never return more than it was given
  a_max_credits: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    credits_out_q <= link_credit_t'(`LINK_NUM_CREDITS));

endmodule

`default_nettype wire

/* hw/link_unpacker.sv */
//////////////////////////////////////////////////////////////////////
// Link unpacker
// Routes incoming payloads to the request or response stream and
// reports accepted packets with their returned credits
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module link_unpacker import link_pkg::*; (
  input  wire logic           clk_i,
  input  wire logic           arst_n_i,
  input  wire logic           rx_valid_i,
  input  wire link_payload_t  rx_payload_i,
  input  wire logic           req_ready_i,
  input  wire logic           rsp_ready_i,
  output logic                rx_ready_o,
  output logic                req_valid_o,
  output link_data_t          req_data_o,
  output logic                rsp_valid_o,
  output link_data_t          rsp_data_o,
  output logic                pkt_acc_o,
  output link_credit_t        credit_ret_o
);

  assign req_valid_o = rx_valid_i & (rx_payload_i.tag == TagReq);
  assign rsp_valid_o = rx_valid_i & (rx_payload_i.tag == TagRsp);
  assign req_data_o  = rx_payload_i.data;
  assign rsp_data_o  = rx_payload_i.data;

  // Ready follows the addressed stream
  always_comb begin
    unique case (rx_payload_i.tag)
      TagReq:  rx_ready_o = req_ready_i;
      TagRsp:  rx_ready_o = rsp_ready_i;
      // Credit-only packets are taken at once
      default: rx_ready_o = 1'b1;
    endcase
  end

  assign pkt_acc_o    = rx_valid_i & rx_ready_o;
  assign credit_ret_o = rx_payload_i.credit;

  a_no_spurious_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !rx_valid_i |-> !req_valid_o && !rsp_valid_o && !pkt_acc_o);

endmodule

`default_nettype wire

/* hw/link_endpoint.sv */
//////////////////////////////////////////////////////////////////////
// Link endpoint
// Packer feeding an output register FIFO, plus the receive unpacker
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "link_defs.svh"

module link_endpoint import link_pkg::*; (
  input  wire logic          clk_i,
  input  wire logic          arst_n_i,
  // User streams into the link
  input  wire logic          req_valid_i,
  output logic               req_ready_o,
  input  wire link_data_t    req_data_i,
  input  wire logic          rsp_valid_i,
  output logic               rsp_ready_o,
  input  wire link_data_t    rsp_data_i,
  // User streams out of the link
  output logic               req_valid_o,
  input  wire logic          req_ready_i,
  output link_data_t         req_data_o,
  output logic               rsp_valid_o,
  input  wire logic          rsp_ready_i,
  output link_data_t         rsp_data_o,
  // Channel side
  output logic               tx_valid_o,
  input  wire logic          tx_ready_i,
  output link_payload_t      tx_payload_o,
  input  wire logic          rx_valid_i,
  output logic               rx_ready_o,
  input  wire link_payload_t rx_payload_i
);

  logic          payload_valid;
  logic          payload_ready;
  link_payload_t payload;
  logic          pkt_acc;
  link_credit_t  credit_ret;

  link_packer u_packer (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .req_valid_i     (req_valid_i),
    .req_data_i      (req_data_i),
    .rsp_valid_i     (rsp_valid_i),
    .rsp_data_i      (rsp_data_i),
    .payload_ready_i (payload_ready),
    .pkt_acc_i       (pkt_acc),
    .credit_ret_i    (credit_ret),
    .req_ready_o     (req_ready_o),
    .rsp_ready_o     (rsp_ready_o),
    .payload_valid_o (payload_valid),
    .payload_o       (payload)
  );

  link_fifo #(
    .DEPTH (`LINK_OUT_DEPTH),
    .T     (link_payload_t)
  ) u_out_fifo (
    .clk_i    (clk_i),         .arst_n_i (arst_n_i),
    .valid_i  (payload_valid), .ready_o  (payload_ready), .data_i (payload),
    .valid_o  (tx_valid_o),    .ready_i  (tx_ready_i),    .data_o (tx_payload_o)
  );

  link_unpacker u_unpacker (
    .clk_i        (clk_i),        .arst_n_i     (arst_n_i),
    .rx_valid_i   (rx_valid_i),   .rx_payload_i (rx_payload_i),
    .req_ready_i  (req_ready_i),  .rsp_ready_i  (rsp_ready_i),
    .rx_ready_o   (rx_ready_o),
    .req_valid_o  (req_valid_o),  .req_data_o   (req_data_o),
    .rsp_valid_o  (rsp_valid_o),  .rsp_data_o   (rsp_data_o),
    .pkt_acc_o    (pkt_acc),      .credit_ret_o (credit_ret)
  );

endmodule

`default_nettype wire

/* hw/link_top.sv */
//////////////////////////////////////////////////////////////////////
// Link top
// Endpoints A and B joined by one channel FIFO per direction
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "link_defs.svh"

module link_top import link_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       arst_n_i,
  // Endpoint A
  input  wire logic       a_req_valid_i,
  output logic            a_req_ready_o,
  input  wire link_data_t a_req_data_i,
  input  wire logic       a_rsp_valid_i,
  output logic            a_rsp_ready_o,
  input  wire link_data_t a_rsp_data_i,
  output logic            a_req_valid_o,
  input  wire logic       a_req_ready_i,
  output link_data_t      a_req_data_o,
  output logic            a_rsp_valid_o,
  input  wire logic       a_rsp_ready_i,
  output link_data_t      a_rsp_data_o,
  // Endpoint B
  input  wire logic       b_req_valid_i,
  output logic            b_req_ready_o,
  input  wire link_data_t b_req_data_i,
  input  wire logic       b_rsp_valid_i,
  output logic            b_rsp_ready_o,
  input  wire link_data_t b_rsp_data_i,
  output logic            b_req_valid_o,
  input  wire logic       b_req_ready_i,
  output link_data_t      b_req_data_o,
  output logic            b_rsp_valid_o,
  input  wire logic       b_rsp_ready_i,
  output link_data_t      b_rsp_data_o
);

  // Channel 0 runs A to B, channel 1 runs B to A
  logic          ch_in_valid  [2];
  logic          ch_in_ready  [2];
  link_payload_t ch_in_data   [2];
  logic          ch_out_valid [2];
  logic          ch_out_ready [2];
  link_payload_t ch_out_data  [2];

  link_endpoint u_ep_a (
    .clk_i        (clk_i),           .arst_n_i     (arst_n_i),
    .req_valid_i  (a_req_valid_i),   .req_ready_o  (a_req_ready_o),
    .req_data_i   (a_req_data_i),
    .rsp_valid_i  (a_rsp_valid_i),   .rsp_ready_o  (a_rsp_ready_o),
    .rsp_data_i   (a_rsp_data_i),
    .req_valid_o  (a_req_valid_o),   .req_ready_i  (a_req_ready_i),
    .req_data_o   (a_req_data_o),
    .rsp_valid_o  (a_rsp_valid_o),   .rsp_ready_i  (a_rsp_ready_i),
    .rsp_data_o   (a_rsp_data_o),
    .tx_valid_o   (ch_in_valid[0]),  .tx_ready_i   (ch_in_ready[0]),
    .tx_payload_o (ch_in_data[0]),
    .rx_valid_i   (ch_out_valid[1]), .rx_ready_o   (ch_out_ready[1]),
    .rx_payload_i (ch_out_data[1])
  );

  link_endpoint u_ep_b (
    .clk_i        (clk_i),           .arst_n_i     (arst_n_i),
    .req_valid_i  (b_req_valid_i),   .req_ready_o  (b_req_ready_o),
    .req_data_i   (b_req_data_i),
    .rsp_valid_i  (b_rsp_valid_i),   .rsp_ready_o  (b_rsp_ready_o),
    .rsp_data_i   (b_rsp_data_i),
    .req_valid_o  (b_req_valid_o),   .req_ready_i  (b_req_ready_i),
    .req_data_o   (b_req_data_o),
    .rsp_valid_o  (b_rsp_valid_o),   .rsp_ready_i  (b_rsp_ready_i),
    .rsp_data_o   (b_rsp_data_o),
    .tx_valid_o   (ch_in_valid[1]),  .tx_ready_i   (ch_in_ready[1]),
    .tx_payload_o (ch_in_data[1]),
    .rx_valid_i   (ch_out_valid[0]), .rx_ready_o   (ch_out_ready[0]),
    .rx_payload_i (ch_out_data[0])
  );

  // Each channel holds as many packets as the sender has credits
  for (genvar i = 0; i < 2; i++) begin : g_channel
    link_fifo #(
      .DEPTH (`LINK_NUM_CREDITS),
      .T     (link_payload_t)
    ) u_channel (
      .clk_i   (clk_i),           .arst_n_i (arst_n_i),
      .valid_i (ch_in_valid[i]),  .ready_o  (ch_in_ready[i]),  .data_i (ch_in_data[i]),
      .valid_o (ch_out_valid[i]), .ready_i  (ch_out_ready[i]), .data_o (ch_out_data[i])
    );
  end

endmodule

`default_nettype wire

/* verif/link_tb.sv */
//////////////////////////////////////////////////////////////////////
// Link testbench
// Drives both endpoints, keeps one scoreboard per stream and checks
// ordering, credit flow and back-pressure with assertions
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "link_defs.svh"

module link_tb import link_pkg::*; ();

  localparam int CLK_PERIOD      = 40;
  localparam int DRIVE_DLY       = 2;
  localparam int RESET_CYCLES    = 16;
  localparam int NUM_CREDITS     = `LINK_NUM_CREDITS;
  localparam int ONE_WAY_ITEMS   = 40;
  localparam int MIXED_ITEMS     = 30;
  localparam int BP_ITEMS        = 30;
  localparam int BP_HOLD_CYCLES  = 100;
  localparam int STARVE_MAX      = 16;
  localparam int TOTAL_ITEMS     = 2 * ONE_WAY_ITEMS + 4 * MIXED_ITEMS + BP_ITEMS +
                                   4 * NUM_CREDITS;
  localparam int WATCHDOG_CYCLES = 200 * TOTAL_ITEMS + 1000;

  // Stream index 0 A req to B, 1 A rsp to B, 2 B req to A, 3 B rsp to A
  logic            clk = 1'b0;
  logic            arst_n;
  logic      [3:0] in_valid;
  wire logic [3:0] in_ready;
  link_data_t      in_data [4];
  wire logic [3:0] out_valid;
  logic      [3:0] out_ready;
  link_data_t      out_data [4];

  link_data_t      sb_q [4][$];
  logic      [3:0] exp_avail;
  link_data_t      exp_head [4];
  int              outstanding [4];
  int              wait_cnt [4];
  int              stall_cycles;
  int              delivered;
  int              err_count;
  int              tests_run;
  logic            bp_hold;
  logic            reset_window;
  logic [31:0]     lcg_state = 32'd69;

  always #(CLK_PERIOD / 2) clk = ~clk;

  link_top i_dut (
    .clk_i         (clk),          .arst_n_i      (arst_n),
    .a_req_valid_i (in_valid[0]),  .a_req_ready_o (in_ready[0]),  .a_req_data_i (in_data[0]),
    .a_rsp_valid_i (in_valid[1]),  .a_rsp_ready_o (in_ready[1]),  .a_rsp_data_i (in_data[1]),
    .a_req_valid_o (out_valid[2]), .a_req_ready_i (out_ready[2]), .a_req_data_o (out_data[2]),
    .a_rsp_valid_o (out_valid[3]), .a_rsp_ready_i (out_ready[3]), .a_rsp_data_o (out_data[3]),
    .b_req_valid_i (in_valid[2]),  .b_req_ready_o (in_ready[2]),  .b_req_data_i (in_data[2]),
    .b_rsp_valid_i (in_valid[3]),  .b_rsp_ready_o (in_ready[3]),  .b_rsp_data_i (in_data[3]),
    .b_req_valid_o (out_valid[0]), .b_req_ready_i (out_ready[0]), .b_req_data_o (out_data[0]),
    .b_rsp_valid_o (out_valid[1]), .b_rsp_ready_i (out_ready[1]), .b_rsp_data_o (out_data[1])
  );

  function automatic link_data_t next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  function automatic string out_name(input int s);
    case (s)
      0:       return "b_req_data_o";
      1:       return "b_rsp_data_o";
      2:       return "a_req_data_o";
      default: return "a_rsp_data_o";
    endcase
  endfunction

  task automatic report_mismatch(input int s);
    if (!exp_avail[s]) begin
      $display("Data left %s while nothing was outstanding on it", out_name(s));
    end else begin
      $display("error %s expected %h actual %h", out_name(s), exp_head[s], out_data[s]);
    end
    err_count++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Scoreboards updated on the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    for (int s = 0; s < 4; s++) begin
      if (arst_n) begin
        if (out_valid[s] && out_ready[s]) begin
          if (sb_q[s].size() != 0) begin
            void'(sb_q[s].pop_front());
          end
          delivered++;
        end
        if (in_valid[s] && in_ready[s]) begin
          sb_q[s].push_back(in_data[s]);
        end
        if (in_valid[s] && !in_ready[s] && !bp_hold) begin
          wait_cnt[s]++;
        end else begin
          wait_cnt[s] = 0;
        end
      end
      outstanding[s] = sb_q[s].size();
      exp_avail[s]   = (sb_q[s].size() != 0);
      exp_head[s]    = exp_avail[s] ? sb_q[s][0] : '0;
    end
    if (bp_hold && in_valid[0] && !in_ready[0]) begin
      stall_cycles++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks sampled mid-cycle while everything is stable
  //////////////////////////////////////////////////////////////////////

  a_reset_quiet: assert property (@(negedge clk) reset_window |-> out_valid == 4'b0)
    else begin
      $display("error out_valid expected %h actual %h", 4'h0, out_valid);
      err_count++;
    end

  // Link plus output FIFO bound what A can hold
  a_bp_bound: assert property (@(negedge clk) disable iff (!arst_n)
    outstanding[0] <= NUM_CREDITS + 2)
    else begin
      $display("Too many requests held between A and B: %0d", outstanding[0]);
      err_count++;
    end

  for (genvar s = 0; s < 4; s++) begin : g_check
    a_in_order: assert property (@(negedge clk) disable iff (!arst_n)
      out_valid[s] && out_ready[s] |-> exp_avail[s] && out_data[s] == exp_head[s])
      else report_mismatch(s);

    a_no_starve: assert property (@(negedge clk) disable iff (!arst_n)
      wait_cnt[s] <= STARVE_MAX)
      else begin
        $display("Input stream %0d waited over %0d cycles for ready", s, STARVE_MAX);
        err_count++;
      end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic send_items(input int s, input int n, input bit gaps);
    int gap;
    for (int k = 0; k < n; k++) begin
      in_valid[s] = 1'b1;
      in_data[s]  = next_rand();
      do begin
        @(negedge clk);
      end while (!in_ready[s]);
      @(posedge clk);
      #DRIVE_DLY;
      in_valid[s] = 1'b0;
      gap = gaps ? int'(next_rand() % 16'd4) : 0;
      repeat (gap) begin
        @(posedge clk);
        #DRIVE_DLY;
      end
    end
  endtask

  task automatic wait_drained();
    while (outstanding[0] + outstanding[1] + outstanding[2] + outstanding[3] != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %s finished, errors so far %0d", tests_run, name, err_count);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) begin
      @(posedge clk);
    end
    $display("Watchdog expired with traffic still outstanding");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    arst_n       = 1'b0;
    in_valid     = 4'b0;
    out_ready    = 4'b1111;
    bp_hold      = 1'b0;
    reset_window = 1'b1;
    stall_cycles = 0;
    delivered    = 0;
    err_count    = 0;
    tests_run    = 0;
    for (int s = 0; s < 4; s++) begin
      in_data[s] = '0;
    end
    repeat (RESET_CYCLES) begin
      @(posedge clk);
    end
    #DRIVE_DLY;
    arst_n = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    reset_window = 1'b0;
    finish_test("reset state");

    send_items(0, ONE_WAY_ITEMS, 1'b0);
    wait_drained();
    send_items(3, ONE_WAY_ITEMS, 1'b0);
    wait_drained();
    finish_test("one-way in-order delivery");

    // Requests at A and responses at B never pause, so the other stream
    // on each side only gets through by winning arbitration
    fork
      send_items(0, MIXED_ITEMS, 1'b0);
      send_items(1, MIXED_ITEMS, 1'b1);
      send_items(2, MIXED_ITEMS, 1'b1);
      send_items(3, MIXED_ITEMS, 1'b0);
    join
    wait_drained();
    finish_test("concurrent traffic");

    // B stops taking requests so A runs out of credits
    out_ready[0] = 1'b0;
    bp_hold      = 1'b1;
    fork
      send_items(0, BP_ITEMS, 1'b0);
      begin
        repeat (BP_HOLD_CYCLES) begin
          @(posedge clk);
        end
        #DRIVE_DLY;
        bp_hold      = 1'b0;
        out_ready[0] = 1'b1;
      end
    join
    wait_drained();
    a_stall_seen: assert (stall_cycles > 0)
      else begin
        $display("a_req_ready_o never fell while b_req_ready_i was held low");
        err_count++;
      end
    finish_test("back-pressure");

    send_items(0, 4 * NUM_CREDITS, 1'b0);
    wait_drained();
    finish_test("credit return on one-way traffic");

    $display("tests %0d, items delivered %0d, errors %0d", tests_run, delivered, err_count);
    if (err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hw
hw/link_pkg.sv
hw/link_fifo.sv
hw/link_packer.sv
hw/link_unpacker.sv
hw/link_endpoint.sv
hw/link_top.sv
verif/link_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the link testbench with Verilator, result read from the log
verilator --binary --timing --assert --top-module link_tb -f flist.f -o link_sim \
  && ./obj_dir/link_sim 2>&1 | tee sim.log \
  && grep -q '>>> PASS' sim.log \
  && ! grep -q '>>> FAIL' sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
